//--- rtl/autotest_params.svh
// vector sizes are whole bytes and the full result layout has to fit in one 512 byte block
`ifndef AUTOTEST_PARAMS_SVH
`define AUTOTEST_PARAMS_SVH

// uut vector sizes in bytes
`define AT_IN_BYTES 4
`define AT_OUT_BYTES 4

// sd block size in bytes
`define AT_BLOCK_BYTES 512

// marks a block that holds a test vector
`define AT_SIGNATURE 32'hAABBCCDD

`define AT_START_BLOCK 32'h0010_0000

// execution cycle limit, small for simulation
`define AT_TIMEOUT 2000

`endif

//--- rtl/autotest_pkg.sv
// shared types only, the uut vector widths come from the byte counts in autotest_params.svh
`default_nettype none

`include "autotest_params.svh"

package autotest_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [9:0] byte_idx_t;
  typedef logic [63:0] cycles_t;
  typedef logic [31:0] err_cnt_t;
  typedef logic [8*`AT_IN_BYTES-1:0] uut_in_t;
  typedef logic [8*`AT_OUT_BYTES-1:0] uut_out_t;

  // read, run and write phases of one block
  typedef enum logic [3:0] {
    idle, sd_reset, sd_reset_wait, block_prep,
    read_open, read_byte, read_byte_wait, check_sig,
    run, capture, compare,
    write_open, write_byte, write_byte_wait, next_block
  } seq_state_e;

endpackage

`default_nettype wire

//--- rtl/vector_loader.sv
// captured fields hold their value until clear_i, bytes outside signature, input and expected are dropped
`default_nettype none
`timescale 1ns/1ps

`include "autotest_params.svh"

module vector_loader (
  input  wire                          clk,
  input  wire                          clear_i,
  input  wire                          load_en_i,
  input  wire autotest_pkg::byte_idx_t byte_idx_i,
  input  wire autotest_pkg::byte_t     data_i,
  output logic [31:0]                  signature_o,
  output autotest_pkg::uut_in_t        uut_in_o,
  output autotest_pkg::uut_out_t       expected_o,
  output logic                         sig_ok_o
);

  import autotest_pkg::*;

  localparam int IN_BASE  = 4;
  localparam int EXP_BASE = IN_BASE + `AT_IN_BYTES;

  always_ff @(posedge clk) begin
    if (clear_i) begin
      signature_o <= '0;
      uut_in_o    <= '0;
      expected_o  <= '0;
    end else if (load_en_i) begin
      // signature arrives msb first
      for (int k = 0; k < 4; k++) begin
        if (byte_idx_i == byte_idx_t'(k)) begin
          signature_o[8*(3-k) +: 8] <= data_i;
        end
      end
      // vectors are byte-lane ordered
      for (int k = 0; k < `AT_IN_BYTES; k++) begin
        if (byte_idx_i == byte_idx_t'(IN_BASE + k)) begin
          uut_in_o[8*k +: 8] <= data_i;
        end
      end
      for (int k = 0; k < `AT_OUT_BYTES; k++) begin
        if (byte_idx_i == byte_idx_t'(EXP_BASE + k)) begin
          expected_o[8*k +: 8] <= data_i;
        end
      end
    end
  end

  assign sig_ok_o = (signature_o == `AT_SIGNATURE);

  // the sequencer must stop loading at the end of the block
  a_load_in_block: assert property (
    @(posedge clk) load_en_i |-> byte_idx_i < byte_idx_t'(`AT_BLOCK_BYTES)
  );

endmodule

`default_nettype wire

//--- rtl/test_runner.sv
// test_done is combinational on the live uut flags, the error count only clears on rst or clear_errors_i
`default_nettype none
`timescale 1ns/1ps

`include "autotest_params.svh"

module test_runner (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         clear_errors_i,
  input  wire                         run_en_i,
  input  wire                         clear_timer_i,
  input  wire                         compare_en_i,
  input  wire                         end_uut_i,
  input  wire                         err_uut_i,
  input  wire autotest_pkg::uut_out_t uut_out_i,
  input  wire autotest_pkg::uut_out_t expected_i,
  output logic                        test_done_o,
  output autotest_pkg::cycles_t       exec_cycles_o,
  output autotest_pkg::uut_out_t      captured_o,
  output autotest_pkg::err_cnt_t      error_count_o
);

  import autotest_pkg::*;

  logic mismatch;

  // execution timer
  always_ff @(posedge clk) begin
    if (rst || clear_timer_i) begin
      exec_cycles_o <= '0;
    end else if (run_en_i) begin
      exec_cycles_o <= exec_cycles_o + 1'b1;
    end
  end

  assign test_done_o = end_uut_i || err_uut_i || (exec_cycles_o > cycles_t'(`AT_TIMEOUT));

  // a uut error counts even with a good output
  assign mismatch = (uut_out_i != expected_i) || err_uut_i;

  always_ff @(posedge clk) begin
    if (compare_en_i) begin
      captured_o <= uut_out_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_errors_i) begin
      error_count_o <= '0;
    end else if (compare_en_i && mismatch) begin
      error_count_o <= error_count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/result_writer.sv
// purely combinational, every offset past the cycle count reads back as FF padding
`default_nettype none
`timescale 1ns/1ps

`include "autotest_params.svh"

module result_writer (
  input  wire autotest_pkg::byte_idx_t byte_idx_i,
  input  wire [31:0]                   signature_i,
  input  wire autotest_pkg::uut_in_t   uut_in_i,
  input  wire autotest_pkg::uut_out_t  expected_i,
  input  wire autotest_pkg::uut_out_t  captured_i,
  input  wire autotest_pkg::cycles_t   exec_cycles_i,
  output autotest_pkg::byte_t          wr_byte_o
);

  import autotest_pkg::*;

  localparam int IN_BASE  = 4;
  localparam int EXP_BASE = IN_BASE + `AT_IN_BYTES;
  localparam int CAP_BASE = EXP_BASE + `AT_OUT_BYTES;
  localparam int CYC_BASE = CAP_BASE + `AT_OUT_BYTES;

  always_comb begin
    wr_byte_o = 8'hFF;
    for (int k = 0; k < 4; k++) begin
      if (byte_idx_i == byte_idx_t'(k)) begin
        wr_byte_o = signature_i[8*(3-k) +: 8];
      end
    end
    for (int k = 0; k < `AT_IN_BYTES; k++) begin
      if (byte_idx_i == byte_idx_t'(IN_BASE + k)) begin
        wr_byte_o = uut_in_i[8*k +: 8];
      end
    end
    for (int k = 0; k < `AT_OUT_BYTES; k++) begin
      if (byte_idx_i == byte_idx_t'(EXP_BASE + k)) begin
        wr_byte_o = expected_i[8*k +: 8];
      end
      if (byte_idx_i == byte_idx_t'(CAP_BASE + k)) begin
        wr_byte_o = captured_i[8*k +: 8];
      end
    end
    // cycle count, low byte first
    for (int k = 0; k < 8; k++) begin
      if (byte_idx_i == byte_idx_t'(CYC_BASE + k)) begin
        wr_byte_o = exec_cycles_i[8*k +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/autotest_sequencer.sv
// every sd request is held until spi_busy_i rises and then waits for it to fall, a bad signature ends the run
`default_nettype none
`timescale 1ns/1ps

`include "autotest_params.svh"

module autotest_sequencer (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  input  wire                       spi_busy_i,
  input  wire                       test_done_i,
  input  wire                       sig_ok_i,
  output logic                      spi_rst_o,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      spi_w_block_o,
  output logic                      spi_w_byte_o,
  output autotest_pkg::block_addr_t spi_block_addr_o,
  output autotest_pkg::byte_idx_t   byte_idx_o,
  output logic                      load_byte_en_o,
  output logic                      clear_vectors_o,
  output logic                      run_en_o,
  output logic                      capture_en_o,
  output logic                      compare_en_o,
  output logic                      rst_uut_o,
  output logic                      busy_o
);

  import autotest_pkg::*;

  localparam byte_idx_t LAST_IDX = byte_idx_t'(`AT_BLOCK_BYTES - 1);

  seq_state_e state;
  seq_state_e state_next;
  logic       busy_seen;
  logic       idx_step;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // block open needs busy to rise and fall once
  always_ff @(posedge clk) begin
    if (rst || state != state_next) begin
      busy_seen <= 1'b0;
    end else if (spi_busy_i) begin
      busy_seen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || (state == idle && start_i)) begin
      spi_block_addr_o <= `AT_START_BLOCK;
    end else if (state == next_block) begin
      spi_block_addr_o <= spi_block_addr_o + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_vectors_o || state == check_sig) begin
      byte_idx_o <= '0;
    end else if (idx_step) begin
      byte_idx_o <= byte_idx_o + 1'b1;
    end
  end

  always_comb begin
    state_next      = state;
    spi_rst_o       = 1'b0;
    spi_r_block_o   = 1'b0;
    spi_r_byte_o    = 1'b0;
    spi_w_block_o   = 1'b0;
    spi_w_byte_o    = 1'b0;
    load_byte_en_o  = 1'b0;
    clear_vectors_o = 1'b0;
    run_en_o        = 1'b0;
    capture_en_o    = 1'b0;
    compare_en_o    = 1'b0;
    rst_uut_o       = 1'b0;
    idx_step        = 1'b0;
    case (state)
      idle: begin
        if (start_i) state_next = sd_reset;
      end
      sd_reset: begin
        spi_rst_o = 1'b1;
        rst_uut_o = 1'b1;
        if (spi_busy_i) state_next = sd_reset_wait;
      end
      sd_reset_wait: begin
        rst_uut_o = 1'b1;
        if (!spi_busy_i) state_next = block_prep;
      end
      block_prep: begin
        rst_uut_o       = 1'b1;
        clear_vectors_o = 1'b1;
        if (!spi_busy_i) state_next = read_open;
      end
      read_open: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        if (busy_seen && !spi_busy_i) state_next = read_byte;
      end
      read_byte: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_next = read_byte_wait;
      end
      read_byte_wait: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          load_byte_en_o = 1'b1;
          idx_step       = 1'b1;
          state_next     = (byte_idx_o == LAST_IDX) ? check_sig : read_byte;
        end
      end
      check_sig: begin
        rst_uut_o  = 1'b1;
        state_next = sig_ok_i ? run : idle;
      end
      run: begin
        run_en_o = 1'b1;
        if (test_done_i) state_next = capture;
      end
      capture: begin
        capture_en_o = 1'b1;
        state_next   = compare;
      end
      compare: begin
        compare_en_o = 1'b1;
        state_next   = write_open;
      end
      write_open: begin
        spi_w_block_o = 1'b1;
        if (busy_seen && !spi_busy_i) state_next = write_byte;
      end
      write_byte: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) state_next = write_byte_wait;
      end
      write_byte_wait: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          idx_step   = 1'b1;
          state_next = (byte_idx_o == LAST_IDX) ? next_block : write_byte;
        end
      end
      next_block: begin
        rst_uut_o  = 1'b1;
        state_next = block_prep;
      end
      default: state_next = idle;
    endcase
  end

  assign busy_o = (state != idle);

  a_one_direction: assert property (@(posedge clk) disable iff (rst)
    (spi_r_block_o || spi_r_byte_o) |-> !(spi_w_block_o || spi_w_byte_o));

endmodule

`default_nettype wire

//--- rtl/autotest_top.sv
// the uut runs until end, error or timeout, and each block is rewritten in place with its result
`default_nettype none
`timescale 1ns/1ps

module autotest_top (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         start_i,
  output logic                        spi_rst_o,
  output logic                        spi_r_block_o,
  output logic                        spi_r_byte_o,
  output logic                        spi_w_block_o,
  output logic                        spi_w_byte_o,
  output autotest_pkg::block_addr_t   spi_block_addr_o,
  output autotest_pkg::byte_t         spi_data_in_o,
  input  wire                         spi_busy_i,
  input  wire autotest_pkg::byte_t    spi_data_out_i,
  output logic                        rst_uut_o,
  output autotest_pkg::uut_in_t       uut_in_o,
  input  wire                         end_uut_i,
  input  wire                         err_uut_i,
  input  wire autotest_pkg::uut_out_t uut_out_i,
  output autotest_pkg::err_cnt_t      error_count_o,
  output logic                        busy_o
);

  import autotest_pkg::*;

  byte_idx_t   byte_idx;
  logic        load_byte_en;
  logic        clear_vectors;
  logic        run_en;
  logic        capture_en;
  logic        compare_en;
  logic        clear_errors;
  logic [31:0] signature;
  uut_out_t    expected;
  uut_out_t    captured;
  logic        sig_ok;
  logic        test_done;
  cycles_t     exec_cycles;

  // a start only counts while idle
  assign clear_errors = start_i && !busy_o;

  autotest_sequencer i_sequencer (
    .clk(clk), .rst(rst), .start_i(start_i), .spi_busy_i(spi_busy_i),
    .test_done_i(test_done), .sig_ok_i(sig_ok),
    .spi_rst_o(spi_rst_o), .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_block_addr_o(spi_block_addr_o), .byte_idx_o(byte_idx),
    .load_byte_en_o(load_byte_en), .clear_vectors_o(clear_vectors), .run_en_o(run_en),
    .capture_en_o(capture_en), .compare_en_o(compare_en), .rst_uut_o(rst_uut_o),
    .busy_o(busy_o)
  );

  vector_loader i_loader (
    .clk(clk), .clear_i(clear_vectors), .load_en_i(load_byte_en), .byte_idx_i(byte_idx),
    .data_i(spi_data_out_i), .signature_o(signature), .uut_in_o(uut_in_o),
    .expected_o(expected), .sig_ok_o(sig_ok)
  );

  // timer also covers the capture cycle
  test_runner i_runner (
    .clk(clk), .rst(rst), .clear_errors_i(clear_errors), .run_en_i(run_en || capture_en),
    .clear_timer_i(clear_vectors), .compare_en_i(compare_en), .end_uut_i(end_uut_i),
    .err_uut_i(err_uut_i), .uut_out_i(uut_out_i), .expected_i(expected),
    .test_done_o(test_done), .exec_cycles_o(exec_cycles), .captured_o(captured),
    .error_count_o(error_count_o)
  );

  result_writer i_writer (
    .byte_idx_i(byte_idx), .signature_i(signature), .uut_in_i(uut_in_o),
    .expected_i(expected), .captured_i(captured), .exec_cycles_i(exec_cycles),
    .wr_byte_o(spi_data_in_o)
  );

endmodule

`default_nettype wire

//--- test/tb_models.sv
// behavioral models that assume 4 byte uut vectors, the sd card serves one request at a time
`default_nettype none
`timescale 1ns/1ps

module sd_card_model (
  input  wire        clk,
  input  wire        rst,
  input  wire        spi_rst_i,
  input  wire        r_block_i,
  input  wire        r_byte_i,
  input  wire        w_block_i,
  input  wire        w_byte_i,
  input  wire [31:0] block_addr_i,
  input  wire [7:0]  data_in_i,
  output logic       busy_o,
  output logic [7:0] data_out_o
);

  logic [7:0]  mem [bit [40:0]];
  logic [31:0] rd_log [$];
  logic [31:0] wr_log [$];
  int          seed = 32'h4751;
  logic [31:0] addr;
  int          idx;
  logic        reading;
  logic        writing;

  // unwritten bytes read back a pattern of the whole address
  function automatic logic [7:0] peek(input logic [31:0] blk, input int k);
    bit [40:0] key;
    key = {blk, k[8:0]};
    if (mem.exists(key)) return mem[key];
    return key[7:0] ^ key[15:8] ^ key[23:16] ^ key[31:24] ^ key[39:32] ^ {7'd0, key[40]};
  endfunction

  task automatic poke(input logic [31:0] blk, input int k, input logic [7:0] val);
    mem[{blk, k[8:0]}] = val;
  endtask

  // busy rises after 0 or 1 cycles and stays up for 1 or 2
  task automatic answer();
    repeat ($unsigned($random(seed)) % 2) @(posedge clk);
    busy_o <= 1'b1;
    repeat (1 + $unsigned($random(seed)) % 2) @(posedge clk);
    busy_o <= 1'b0;
    // the old request is still visible on this edge
    @(posedge clk);
  endtask

  initial begin
    busy_o     = 1'b0;
    data_out_o = 8'h00;
    reading    = 1'b0;
    writing    = 1'b0;
    addr       = '0;
    idx        = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        reading = 1'b0;
        writing = 1'b0;
      end else if (spi_rst_i) begin
        answer();
      end else if (r_block_i && !reading) begin
        reading = 1'b1;
        addr    = block_addr_i;
        idx     = 0;
        rd_log.push_back(addr);
        answer();
      end else if (r_byte_i) begin
        data_out_o <= peek(addr, idx);
        idx++;
        answer();
      end else if (w_block_i && !writing) begin
        writing = 1'b1;
        addr    = block_addr_i;
        idx     = 0;
        answer();
      end else if (w_byte_i) begin
        poke(addr, idx, data_in_i);
        idx++;
        answer();
      end else begin
        if (!r_block_i) reading = 1'b0;
        if (writing && !w_block_i) begin
          wr_log.push_back(addr);
          writing = 1'b0;
        end
      end
    end
  end

endmodule

module uut_model (
  input  wire         clk,
  input  wire         rst_uut_i,
  input  wire  [31:0] in_i,
  output logic        end_o,
  output logic        err_o,
  output logic [31:0] out_o
);

  logic [7:0] cnt;
  logic       hang;

  assign hang  = (in_i == 32'hFFFF_FFFF);
  assign out_o = in_i + 32'd1;

  initial begin
    cnt   = 8'd0;
    end_o = 1'b0;
    err_o = 1'b0;
  end

  // end and err hold until the next uut reset
  always @(posedge clk) begin
    if (rst_uut_i) begin
      cnt   <= 8'd0;
      end_o <= 1'b0;
      err_o <= 1'b0;
    end else if (!end_o && !hang) begin
      cnt <= cnt + 8'd1;
      if (cnt == {2'b00, in_i[5:0]} + 8'd3) begin
        end_o <= 1'b1;
        err_o <= in_i[31];
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_autotest.sv
// five vector blocks and one bad signature block, run twice, with 4 byte uut vectors assumed
`default_nettype none
`timescale 1ns/1ps

`include "autotest_params.svh"

module tb_autotest;

  import autotest_pkg::*;

  localparam int N_VECTORS    = 5;
  localparam int BLOCK_CYCLES = 8000;
  // two runs of six blocks, each run with one hanging uut
  localparam int WATCHDOG_CYCLES = 2 * (N_VECTORS + 1) * BLOCK_CYCLES + 2 * `AT_TIMEOUT;
  localparam int IN_BASE  = 4;
  localparam int EXP_BASE = IN_BASE + `AT_IN_BYTES;
  localparam int CAP_BASE = EXP_BASE + `AT_OUT_BYTES;
  localparam int CYC_BASE = CAP_BASE + `AT_OUT_BYTES;
  localparam int PAD_BASE = CYC_BASE + 8;

  logic        clk;
  logic        rst;
  logic        start;
  logic        spi_rst;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_w_block;
  logic        spi_w_byte;
  block_addr_t spi_block_addr;
  byte_t       spi_data_in;
  logic        spi_busy;
  byte_t       spi_data_out;
  logic        rst_uut;
  uut_in_t     uut_in;
  logic        end_uut;
  logic        err_uut;
  uut_out_t    uut_out;
  err_cnt_t    error_count;
  logic        busy;
  int          mismatches;
  int          failures;

  // pass, wrong expected, uut error, hang, pass
  uut_in_t  vec_in [N_VECTORS] = '{32'h0000_0005, 32'h0000_0010, 32'h8000_0003,
                                   32'hFFFF_FFFF, 32'h0000_0021};
  uut_out_t vec_exp [N_VECTORS] = '{32'h0000_0006, 32'h1234_5678, 32'h8000_0004,
                                    32'h0000_0001, 32'h0000_0022};

  autotest_top i_dut (
    .clk(clk), .rst(rst), .start_i(start),
    .spi_rst_o(spi_rst), .spi_r_block_o(spi_r_block), .spi_r_byte_o(spi_r_byte),
    .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte),
    .spi_block_addr_o(spi_block_addr), .spi_data_in_o(spi_data_in),
    .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .rst_uut_o(rst_uut), .uut_in_o(uut_in), .end_uut_i(end_uut), .err_uut_i(err_uut),
    .uut_out_i(uut_out), .error_count_o(error_count), .busy_o(busy)
  );

  sd_card_model i_sd (
    .clk(clk), .rst(rst), .spi_rst_i(spi_rst), .r_block_i(spi_r_block),
    .r_byte_i(spi_r_byte), .w_block_i(spi_w_block), .w_byte_i(spi_w_byte),
    .block_addr_i(spi_block_addr), .data_in_i(spi_data_in),
    .busy_o(spi_busy), .data_out_o(spi_data_out)
  );

  uut_model i_uut (
    .clk(clk), .rst_uut_i(rst_uut), .in_i(uut_in),
    .end_o(end_uut), .err_o(err_uut), .out_o(uut_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  a_reset_follows_start: assert property (@(posedge clk) disable iff (rst)
    start && !busy |=> spi_rst) else begin
    failures++;
    $display("spi_rst_o did not rise on the cycle after a start while idle");
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got == exp) else begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      failures++;
      $display("%s", what);
    end
  endtask

  // uut rules: output is input plus 1, bit 31 flags an error unless the input hangs
  function automatic int error_step(input uut_in_t in, input uut_out_t exp);
    logic uut_err;
    uut_err = in[31] && (in != '1);
    return ((uut_out_t'(in + 32'd1) != exp) || uut_err) ? 1 : 0;
  endfunction

  task automatic store_vector(input block_addr_t blk, input logic [31:0] sig,
                              input uut_in_t in, input uut_out_t exp);
    for (int b = 0; b < 4; b++) i_sd.poke(blk, b, sig[8*(3-b) +: 8]);
    for (int b = 0; b < `AT_IN_BYTES; b++) i_sd.poke(blk, IN_BASE + b, in[8*b +: 8]);
    for (int b = 0; b < `AT_OUT_BYTES; b++) i_sd.poke(blk, EXP_BASE + b, exp[8*b +: 8]);
  endtask

  task automatic verify_result_block(input int k);
    block_addr_t blk;
    logic [31:0] sig;
    uut_out_t    out;
    logic [63:0] cycles;
    blk = block_addr_t'(`AT_START_BLOCK + k);
    sig = `AT_SIGNATURE;
    out = uut_out_t'(vec_in[k] + 32'd1);
    for (int b = 0; b < 4; b++)
      compare_value($sformatf("block %0d signature byte %0d", k, b),
                    i_sd.peek(blk, b), sig[8*(3-b) +: 8]);
    for (int b = 0; b < `AT_IN_BYTES; b++)
      compare_value($sformatf("block %0d input byte %0d", k, b),
                    i_sd.peek(blk, IN_BASE + b), vec_in[k][8*b +: 8]);
    for (int b = 0; b < `AT_OUT_BYTES; b++) begin
      compare_value($sformatf("block %0d expected byte %0d", k, b),
                    i_sd.peek(blk, EXP_BASE + b), vec_exp[k][8*b +: 8]);
      compare_value($sformatf("block %0d output byte %0d", k, b),
                    i_sd.peek(blk, CAP_BASE + b), out[8*b +: 8]);
    end
    for (int b = 0; b < 8; b++) cycles[8*b +: 8] = i_sd.peek(blk, CYC_BASE + b);
    if (vec_in[k] == '1) begin
      require(cycles > `AT_TIMEOUT, $sformatf("block %0d hang stopped before timeout", k));
    end else begin
      require(cycles != 0 && cycles <= `AT_TIMEOUT,
              $sformatf("block %0d cycle count %0d out of range", k, cycles));
    end
    for (int b = PAD_BASE; b < `AT_BLOCK_BYTES; b++)
      compare_value($sformatf("block %0d padding byte %0d", k, b), i_sd.peek(blk, b), 8'hFF);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_write_end();
    logic was_high;
    was_high = 1'b0;
    while (!(was_high && !spi_w_block)) begin
      was_high = spi_w_block;
      @(posedge clk);
    end
  endtask

  task automatic wait_idle();
    while (busy) @(posedge clk);
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run not finished after %0d cycles", WATCHDOG_CYCLES);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int exp_errors;
    rst        = 1'b1;
    start      = 1'b0;
    mismatches = 0;
    failures   = 0;
    exp_errors = 0;
    for (int k = 0; k < N_VECTORS; k++)
      store_vector(block_addr_t'(`AT_START_BLOCK + k), `AT_SIGNATURE, vec_in[k], vec_exp[k]);
    store_vector(block_addr_t'(`AT_START_BLOCK + N_VECTORS), 32'h1122_3344, '0, '0);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    require(!(spi_rst || spi_r_block || spi_r_byte || spi_w_block || spi_w_byte),
            "an sd strobe is high after reset");
    require(!rst_uut && !busy, "rst_uut_o or busy_o is high after reset");
    compare_value("error_count_o", error_count, 0);
    compare_value("spi_block_addr_o", spi_block_addr, `AT_START_BLOCK);

    pulse_start();
    for (int k = 0; k < N_VECTORS; k++) begin
      wait_write_end();
      exp_errors += error_step(vec_in[k], vec_exp[k]);
      compare_value($sformatf("error_count_o after block %0d", k), error_count, exp_errors);
      verify_result_block(k);
    end
    wait_idle();
    require(i_sd.rd_log.size() == N_VECTORS + 1, "wrong number of block reads");
    require(i_sd.wr_log.size() == N_VECTORS, "wrong number of block writes");
    for (int k = 0; k < N_VECTORS + 1; k++)
      if (k < i_sd.rd_log.size())
        compare_value($sformatf("read address %0d", k), i_sd.rd_log[k], `AT_START_BLOCK + k);
    for (int k = 0; k < N_VECTORS; k++)
      if (k < i_sd.wr_log.size())
        compare_value($sformatf("write address %0d", k), i_sd.wr_log[k], `AT_START_BLOCK + k);

    // the rewritten blocks hold the same vectors, so the second run repeats the count
    pulse_start();
    @(posedge clk);
    compare_value("error_count_o after restart", error_count, 0);
    compare_value("spi_block_addr_o after restart", spi_block_addr, `AT_START_BLOCK);
    wait_idle();
    require(i_sd.rd_log.size() == 2 * (N_VECTORS + 1), "wrong number of reads after restart");
    if (i_sd.rd_log.size() > N_VECTORS + 1)
      compare_value("first read address after restart", i_sd.rd_log[N_VECTORS + 1],
                    `AT_START_BLOCK);
    compare_value("error_count_o after second run", error_count, exp_errors);

    print_counts();
    if (mismatches + failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/autotest_pkg.sv
rtl/vector_loader.sv
rtl/test_runner.sv
rtl/result_writer.sv
rtl/autotest_sequencer.sv
rtl/autotest_top.sv
test/tb_models.sv
test/tb_autotest.sv

//--- run.sh
#!/bin/sh
# Builds the autotest testbench with Verilator and runs it once.
# The exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_autotest -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_autotest)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1
